// File: build.f
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/pc.sv
hw/decode.sv
hw/memory_port.sv
hw/execute_mem.sv
hw/control.sv
hw/cpu.sv
verification/cpu_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run cpu_tb and check the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module cpu_tb -f build.f -o cpu_tb
	./obj_dir/cpu_tb | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module cpu_tb;

    localparam int MEM_WORDS    = 512;
    localparam int RANDOM_COUNT = 30;
    localparam int DATA_ADDR    = 'h400;
    localparam int RESULT_ADDR  = 'h600;

    logic           clk = 1'b0;
    logic           rst_n = 1'b0;
    logic           bus_ready = 1'b0;
    logic [29:0]    bus_addr;
    isa_pkg::word_t bus_write_data;
    logic [3:0]     bus_byte_enable;
    logic           bus_write_req;
    logic           bus_read_req;
    isa_pkg::word_t bus_read_data = '0;
    logic           bus_read_data_valid = 1'b0;

    isa_pkg::word_t mem [MEM_WORDS];
    int prog_len;
    int stores_matched = 0;
    logic [29:0] loop_addr;
    logic [29:0] exp_reads [$];
    logic [29:0] exp_store_addr [$];
    isa_pkg::word_t exp_store_data [$];

    // read in flight, and the request left waiting at the last edge.
    logic read_pending = 1'b0;
    int read_wait;
    logic [29:0] read_addr;
    logic held = 1'b0;
    logic held_write;
    logic [29:0] held_addr;
    isa_pkg::word_t held_data;

    cpu cpu_inst (.clk(clk), .rst_n(rst_n), .bus_ready(bus_ready), .bus_addr(bus_addr),
        .bus_write_data(bus_write_data), .bus_byte_enable(bus_byte_enable),
        .bus_write_req(bus_write_req), .bus_read_req(bus_read_req),
        .bus_read_data(bus_read_data), .bus_read_data_valid(bus_read_data_valid));

    always #5 clk = ~clk;

    task automatic abort_run(string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // ####################
    // instruction encoding
    // ####################

    function automatic isa_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, isa_pkg::OP};
    endfunction

    function automatic isa_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                              logic [4:0] rd, isa_pkg::opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic isa_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], isa_pkg::STORE};
    endfunction

    function automatic isa_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::BRANCH};
    endfunction

    function automatic isa_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::JAL};
    endfunction

    task automatic emit(isa_pkg::word_t word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    // register, immediate or LUI form with rd anywhere in x0..x15.
    task automatic emit_random_alu();
        int kind;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        kind = int'($urandom % 3);
        f3   = 3'($urandom % 8);
        rd   = 5'($urandom % 16);
        rs1  = 5'($urandom % 16);
        rs2  = 5'($urandom % 16);
        if (f3 == 3'b011) begin
            f3 = 3'b000;
        end
        if (kind == 0) begin
            emit(r_type((f3 == 3'd0 && $urandom % 2 == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
        end else if (kind == 1) begin
            emit(i_type((f3 == 3'd1 || f3 == 3'd5) ? {7'h00, rs2} : 12'($urandom),
                        rs1, f3, rd, isa_pkg::OP_IMM));
        end else begin
            emit({20'($urandom), rd, isa_pkg::LUI});
        end
    endtask

    task automatic build_program();
        logic [4:0] ld_rd;
        logic [4:0] jal_rd;
        logic [4:0] other_rd;
        logic [4:0] same;
        ld_rd    = 5'(1 + $urandom % 15);
        jal_rd   = ld_rd % 5'd15 + 5'd1;
        other_rd = jal_rd % 5'd15 + 5'd1;
        same     = 5'($urandom % 16);
        prog_len = 0;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            emit_random_alu();
        end
        emit(i_type(12'(DATA_ADDR), 5'd0, 3'b010, ld_rd, isa_pkg::LOAD));
        // taken beq over an addi that would clobber the loaded word.
        emit(b_type(13'd8, 5'd0, 5'd0, 3'b000));
        emit(i_type(12'h7ff, 5'd0, 3'b000, ld_rd, isa_pkg::OP_IMM));
        emit(b_type(13'd8, same, same, 3'b001));
        emit(r_type(7'h00, ld_rd, ld_rd, 3'b000, other_rd));
        emit(j_type(21'd8, jal_rd));
        emit(i_type(12'h7ff, 5'd0, 3'b000, ld_rd, isa_pkg::OP_IMM));
        for (int i = 1; i <= 15; i++) begin
            emit(s_type(12'(RESULT_ADDR + 4 * (i - 1)), 5'(i), 5'd0));
        end
        emit(j_type(21'd0, 5'd0));
    endtask

    // ####################
    // reference model
    // ####################

    function automatic isa_pkg::word_t model_alu(logic [2:0] f3, logic sub, isa_pkg::word_t a,
                                                 isa_pkg::word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // runs the program once and queues every expected bus read and store.
    task automatic run_model();
        isa_pkg::word_t regs [32];
        isa_pkg::word_t pc_m;
        isa_pkg::word_t next_pc;
        isa_pkg::word_t insn;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t res;
        isa_pkg::word_t imm_i;
        isa_pkg::word_t imm_s;
        isa_pkg::word_t imm_b;
        isa_pkg::word_t imm_j;
        logic writes;
        logic done;
        int steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc_m  = `CPU_RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4096) begin
            exp_reads.push_back(pc_m[31:2]);
            insn    = mem[pc_m[10:2]];
            a       = regs[insn[19:15]];
            b       = regs[insn[24:20]];
            imm_i   = {{20{insn[31]}}, insn[31:20]};
            imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            imm_j   = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
            next_pc = pc_m + 32'd4;
            writes  = 1'b1;
            res     = '0;
            case (isa_pkg::opcode_e'(insn[6:0]))
                isa_pkg::OP:     res = model_alu(insn[14:12], insn[30], a, b);
                isa_pkg::OP_IMM: res = model_alu(insn[14:12], 1'b0, a, imm_i);
                isa_pkg::LUI:    res = {insn[31:12], 12'b0};
                isa_pkg::LOAD: begin
                    exp_reads.push_back(30'((a + imm_i) >> 2));
                    res = mem[9'((a + imm_i) >> 2)];
                end
                isa_pkg::STORE: begin
                    writes = 1'b0;
                    exp_store_addr.push_back(30'((a + imm_s) >> 2));
                    exp_store_data.push_back(b);
                end
                isa_pkg::BRANCH: begin
                    writes = 1'b0;
                    if ((a == b) == (insn[14:12] == 3'b000)) begin
                        next_pc = pc_m + imm_b;
                    end
                end
                isa_pkg::JAL: begin
                    res     = pc_m + 32'd4;
                    next_pc = pc_m + imm_j;
                    done    = next_pc == pc_m;
                end
                default: writes = 1'b0;
            endcase
            if (writes && insn[11:7] != 5'd0) begin
                regs[insn[11:7]] = res;
            end
            pc_m = next_pc;
            steps++;
        end
        loop_addr = pc_m[31:2];
    endtask

    // ####################
    // checks
    // ####################

    task automatic check_fetch(logic [29:0] addr);
        logic [29:0] want;
        if (exp_reads.size() > 0) begin
            want = exp_reads.pop_front();
        end else begin
            want = loop_addr;
        end
        if (addr != want) begin
            abort_run($sformatf("FAILED at %0t: read address %h, expected %h",
                                $time, addr, want));
        end
    endtask

    task automatic check_store(logic [29:0] addr, isa_pkg::word_t data, logic [3:0] byte_enable);
        logic [29:0] want_addr;
        isa_pkg::word_t want_data;
        if (exp_store_addr.size() == 0) begin
            abort_run("the core made a store that the program does not contain");
        end
        want_addr = exp_store_addr.pop_front();
        want_data = exp_store_data.pop_front();
        if (addr != want_addr || data != want_data || byte_enable != 4'b1111) begin
            abort_run($sformatf("FAILED at %0t: store %h <= %h be %b, expected %h <= %h be 1111",
                                $time, addr, data, byte_enable, want_addr, want_data));
        end
        stores_matched++;
    endtask

    // ####################
    // bus memory model
    // ####################

    always @(posedge clk) begin
        if (rst_n) begin
            if (held && (!(bus_read_req || bus_write_req) || bus_addr != held_addr ||
                         bus_write_req != held_write ||
                         (held_write && bus_write_data != held_data))) begin
                abort_run("a bus request changed before bus_ready accepted it");
            end
            if (bus_write_req && bus_ready) begin
                check_store(bus_addr, bus_write_data, bus_byte_enable);
            end
            if (bus_read_req && bus_ready) begin
                check_fetch(bus_addr);
                read_pending = 1'b1;
                read_addr    = bus_addr;
                read_wait    = int'($urandom % 4);
            end
            held       = (bus_read_req || bus_write_req) && !bus_ready;
            held_write = bus_write_req;
            held_addr  = bus_addr;
            held_data  = bus_write_data;
        end
        #1;
        bus_read_data_valid = 1'b0;
        if (read_pending && read_wait == 0) begin
            bus_read_data       = mem[read_addr[8:0]];
            bus_read_data_valid = 1'b1;
            read_pending        = 1'b0;
        end else if (read_pending) begin
            read_wait--;
        end
        // about one cycle in four stalls.
        bus_ready = ($urandom % 4) != 0;
    end

    initial begin
        int limit;
        int cycles;
        void'($urandom(32'h0963_c231));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc0de_0000 ^ i;
        end
        mem[DATA_ADDR / 4] = $urandom;
        build_program();
        run_model();
        repeat (3) begin
            @(posedge clk);
            #1;
            if (bus_read_req || bus_write_req) begin
                abort_run("a bus request was raised while reset was asserted");
            end
        end
        rst_n  = 1'b1;
        limit  = prog_len * 40;
        cycles = 0;
        while (stores_matched < 15 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (stores_matched == 15) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run($sformatf("timeout: the core hung, %0d of 15 stores seen in %0d cycles",
                                stores_matched, cycles));
        end
    end

endmodule

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            bus_ready,
    output logic [29:0]     bus_addr,
    output isa_pkg::word_t  bus_write_data,
    output logic [3:0]      bus_byte_enable,
    output logic            bus_write_req,
    output logic            bus_read_req,
    input  isa_pkg::word_t  bus_read_data,
    input  logic            bus_read_data_valid
);

    logic fetch_enable;
    logic decode_enable;
    logic decode_ready;
    logic execute_enable;
    logic execute_ready;
    logic needs_memory;
    logic memory_enable;
    logic mem_ready;
    logic writeback_enable;

    isa_pkg::word_t pc_value;
    isa_pkg::word_t pc_target;
    logic pc_advance;
    logic pc_load;

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    isa_pkg::word_t rs1_data;
    isa_pkg::word_t rs2_data;
    logic reg_write_enable;
    logic [4:0] reg_write_addr;
    isa_pkg::word_t reg_write_data;

    logic data_enable;
    logic data_write;
    isa_pkg::word_t data_addr;
    isa_pkg::word_t data_wdata;
    isa_pkg::word_t data_rdata;
    logic data_valid;
    logic fetch_valid;

    isa_pkg::opcode_e opcode;
    logic [2:0] funct3;
    logic funct7_bit;
    isa_pkg::word_t imm;

    isa_pkg::alu_op_e alu_op;
    isa_pkg::word_t alu_lhs;
    isa_pkg::word_t alu_rhs;
    isa_pkg::word_t alu_res;

    control control0 (.clk(clk), .rst_n(rst_n),
        .fetch_enable(fetch_enable), .fetch_ready(mem_ready),
        .decode_enable(decode_enable), .decode_ready(decode_ready),
        .execute_enable(execute_enable), .execute_ready(execute_ready),
        .execute_needs_memory(needs_memory),
        .memory_enable(memory_enable), .memory_ready(mem_ready),
        .writeback_enable(writeback_enable));

    pc pc0 (.clk(clk), .rst_n(rst_n), .advance(pc_advance), .load(pc_load),
        .target(pc_target), .value(pc_value));

    register_file register_file0 (.clk(clk), .rst_n(rst_n),
        .read_addr1(rs1), .read_addr2(rs2),
        .read_data1(rs1_data), .read_data2(rs2_data),
        .write_enable(reg_write_enable), .write_addr(reg_write_addr),
        .write_data(reg_write_data));

    memory_port memory_port0 (.clk(clk), .rst_n(rst_n),
        .fetch_enable(fetch_enable), .fetch_addr(pc_value),
        .data_enable(data_enable), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .ready(mem_ready), .fetch_valid(fetch_valid),
        .data_rdata(data_rdata), .data_valid(data_valid),
        .bus_ready(bus_ready), .bus_addr(bus_addr), .bus_write_data(bus_write_data),
        .bus_byte_enable(bus_byte_enable), .bus_write_req(bus_write_req),
        .bus_read_req(bus_read_req), .bus_read_data(bus_read_data),
        .bus_read_data_valid(bus_read_data_valid));

    decode decode0 (.clk(clk), .rst_n(rst_n), .enable(decode_enable),
        .fetch_valid(fetch_valid), .read_data(data_rdata), .ready(decode_ready),
        .opcode(opcode), .funct3(funct3), .funct7_bit(funct7_bit),
        .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm));

    alu alu0 (.op(alu_op), .lhs(alu_lhs), .rhs(alu_rhs), .res(alu_res));

    // execute_mem is started again at MEMORY entry to launch its access.
    execute_mem execute_mem0 (.clk(clk), .rst_n(rst_n),
        .enable(execute_enable | memory_enable), .writeback_enable(writeback_enable),
        .opcode(opcode), .funct3(funct3), .funct7_bit(funct7_bit), .rd(rd), .imm(imm),
        .pc(pc_value), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_op(alu_op), .alu_lhs(alu_lhs), .alu_rhs(alu_rhs), .alu_res(alu_res),
        .ready(execute_ready), .needs_memory(needs_memory),
        .data_enable(data_enable), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .memory_valid(data_valid), .memory_rdata(data_rdata),
        .pc_advance(pc_advance), .pc_load(pc_load), .pc_target(pc_target),
        .reg_write_enable(reg_write_enable), .reg_write_addr(reg_write_addr),
        .reg_write_data(reg_write_data));

endmodule

// File: hw/control.sv
`timescale 1ns/1ps

module control (
    input  logic clk,
    input  logic rst_n,
    output logic fetch_enable,
    input  logic fetch_ready,
    output logic decode_enable,
    input  logic decode_ready,
    output logic execute_enable,
    input  logic execute_ready,
    input  logic execute_needs_memory,
    output logic memory_enable,
    input  logic memory_ready,
    output logic writeback_enable
);

    core_pkg::ctrl_state_e state;
    logic booted;

    // enables are one-cycle pulses issued on entry to a state.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= core_pkg::FETCH;
            booted           <= 1'b0;
            fetch_enable     <= 1'b0;
            decode_enable    <= 1'b0;
            execute_enable   <= 1'b0;
            memory_enable    <= 1'b0;
            writeback_enable <= 1'b0;
        end else begin
            fetch_enable     <= 1'b0;
            decode_enable    <= 1'b0;
            execute_enable   <= 1'b0;
            memory_enable    <= 1'b0;
            writeback_enable <= 1'b0;
            booted           <= 1'b1;
            case (state)
                core_pkg::FETCH: begin
                    if (!booted) begin
                        fetch_enable <= 1'b1;
                    end else if (fetch_ready) begin
                        state         <= core_pkg::DECODE;
                        decode_enable <= 1'b1;
                    end
                end
                core_pkg::DECODE: begin
                    if (decode_ready) begin
                        state          <= core_pkg::EXECUTE;
                        execute_enable <= 1'b1;
                    end
                end
                core_pkg::EXECUTE: begin
                    if (execute_ready && execute_needs_memory) begin
                        state         <= core_pkg::MEMORY;
                        memory_enable <= 1'b1;
                    end else if (execute_ready) begin
                        state            <= core_pkg::WRITEBACK;
                        writeback_enable <= 1'b1;
                    end
                end
                core_pkg::MEMORY: begin
                    if (memory_ready) begin
                        state            <= core_pkg::WRITEBACK;
                        writeback_enable <= 1'b1;
                    end
                end
                default: begin
                    state        <= core_pkg::FETCH;
                    fetch_enable <= 1'b1;
                end
            endcase
        end
    end

    // a stage reports ready only while control waits for it.
    ready_in_state: assert property (@(posedge clk) disable iff (!rst_n)
        (!decode_ready || state == core_pkg::DECODE) &&
        (!execute_ready || state == core_pkg::EXECUTE));

endmodule

// File: hw/execute_mem.sv
`timescale 1ns/1ps

module execute_mem (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              writeback_enable,
    input  isa_pkg::opcode_e  opcode,
    input  logic [2:0]        funct3,
    input  logic              funct7_bit,
    input  logic [4:0]        rd,
    input  isa_pkg::word_t    imm,
    input  isa_pkg::word_t    pc,
    input  isa_pkg::word_t    rs1_data,
    input  isa_pkg::word_t    rs2_data,
    output isa_pkg::alu_op_e  alu_op,
    output isa_pkg::word_t    alu_lhs,
    output isa_pkg::word_t    alu_rhs,
    input  isa_pkg::word_t    alu_res,
    output logic              ready,
    output logic              needs_memory,
    output logic              data_enable,
    output logic              data_write,
    output isa_pkg::word_t    data_addr,
    output isa_pkg::word_t    data_wdata,
    input  logic              memory_valid,
    input  isa_pkg::word_t    memory_rdata,
    output logic              pc_advance,
    output logic              pc_load,
    output isa_pkg::word_t    pc_target,
    output logic              reg_write_enable,
    output logic [4:0]        reg_write_addr,
    output isa_pkg::word_t    reg_write_data
);

    logic mem_pending;
    logic take_q;
    logic write_q;
    logic taken;
    isa_pkg::word_t result_q;
    isa_pkg::word_t target_q;

    // ####################
    // operand and op select
    // ####################

    always_comb begin
        alu_op = isa_pkg::ADD;
        if (opcode == isa_pkg::OP || opcode == isa_pkg::OP_IMM) begin
            case (funct3)
                isa_pkg::F3_ADD: alu_op = (opcode == isa_pkg::OP && funct7_bit) ?
                                          isa_pkg::SUB : isa_pkg::ADD;
                isa_pkg::F3_SLL: alu_op = isa_pkg::SLL;
                isa_pkg::F3_SLT: alu_op = isa_pkg::SLT;
                isa_pkg::F3_XOR: alu_op = isa_pkg::XOR;
                isa_pkg::F3_SRL: alu_op = isa_pkg::SRL;
                isa_pkg::F3_OR:  alu_op = isa_pkg::OR;
                isa_pkg::F3_AND: alu_op = isa_pkg::AND;
                default:         alu_op = isa_pkg::ADD;
            endcase
        end else if (opcode == isa_pkg::BRANCH) begin
            alu_op = isa_pkg::SUB;
        end
    end

    // JAL borrows the ALU for its pc+4 link value.
    assign alu_lhs = (opcode == isa_pkg::LUI) ? '0 :
                     (opcode == isa_pkg::JAL) ? pc : rs1_data;
    assign alu_rhs = (opcode == isa_pkg::OP || opcode == isa_pkg::BRANCH) ? rs2_data :
                     (opcode == isa_pkg::JAL) ? 32'd4 : imm;

    assign taken = (opcode == isa_pkg::JAL) ||
                   (opcode == isa_pkg::BRANCH &&
                    ((alu_res == '0) == (funct3 == isa_pkg::F3_BEQ)));

    // ####################
    // stage handshake
    // ####################

    // enable also arrives at the start of MEMORY, then it launches the access.
    assign needs_memory = opcode == isa_pkg::LOAD || opcode == isa_pkg::STORE;
    assign ready        = enable && !mem_pending;
    assign data_enable  = enable && mem_pending;
    assign data_write   = opcode == isa_pkg::STORE;
    assign data_addr    = result_q;
    assign data_wdata   = rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_pending <= 1'b0;
            take_q      <= 1'b0;
            write_q     <= 1'b0;
        end else if (ready) begin
            mem_pending <= needs_memory;
            take_q      <= taken;
            write_q     <= opcode != isa_pkg::STORE && opcode != isa_pkg::BRANCH;
        end else if (data_enable) begin
            mem_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            result_q <= alu_res;
            target_q <= pc + imm;
        end else if (memory_valid) begin
            result_q <= memory_rdata;
        end
    end

    assign pc_load          = writeback_enable && take_q;
    assign pc_advance       = writeback_enable && !take_q;
    assign pc_target        = target_q;
    assign reg_write_enable = writeback_enable && write_q;
    assign reg_write_addr   = rd;
    assign reg_write_data   = result_q;

endmodule

// File: hw/memory_port.sv
`timescale 1ns/1ps

module memory_port (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_enable,
    input  isa_pkg::word_t  fetch_addr,
    input  logic            data_enable,
    input  logic            data_write,
    input  isa_pkg::word_t  data_addr,
    input  isa_pkg::word_t  data_wdata,
    output logic            ready,
    output logic            fetch_valid,
    output isa_pkg::word_t  data_rdata,
    output logic            data_valid,
    input  logic            bus_ready,
    output logic [29:0]     bus_addr,
    output isa_pkg::word_t  bus_write_data,
    output logic [3:0]      bus_byte_enable,
    output logic            bus_write_req,
    output logic            bus_read_req,
    input  isa_pkg::word_t  bus_read_data,
    input  logic            bus_read_data_valid
);

    logic busy;
    logic waiting;
    logic write_q;
    isa_pkg::word_t addr_q;
    isa_pkg::word_t wdata_q;
    core_pkg::ctrl_state_e owner;
    logic read_done;

    assign bus_read_req    = busy && !write_q;
    assign bus_write_req   = busy && write_q;
    assign bus_addr        = addr_q[31:2];
    assign bus_write_data  = wdata_q;
    assign bus_byte_enable = 4'b1111;

    // a write ends on acceptance, a read when its data comes back.
    assign read_done   = waiting && bus_read_data_valid;
    assign ready       = (bus_write_req && bus_ready) || read_done;
    assign fetch_valid = read_done && owner == core_pkg::FETCH;
    assign data_valid  = read_done && owner == core_pkg::MEMORY;
    assign data_rdata  = bus_read_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            waiting <= 1'b0;
            write_q <= 1'b0;
            owner   <= core_pkg::FETCH;
        end else if (fetch_enable) begin
            busy    <= 1'b1;
            write_q <= 1'b0;
            owner   <= core_pkg::FETCH;
        end else if (data_enable) begin
            busy    <= 1'b1;
            write_q <= data_write;
            owner   <= core_pkg::MEMORY;
        end else if (busy && bus_ready) begin
            busy    <= 1'b0;
            waiting <= !write_q;
        end else if (read_done) begin
            waiting <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_enable) begin
            addr_q <= fetch_addr;
        end else if (data_enable) begin
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
        end
    end

    request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_read_req || bus_write_req) && !bus_ready |=>
            $stable(bus_addr) && $stable(bus_write_data) &&
            $stable(bus_read_req) && $stable(bus_write_req));

    // fetch and data requests are never started together.
    request_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_enable && data_enable));

    // a data access only follows a completed fetch.
    data_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        data_enable |-> !busy && !waiting && owner == core_pkg::FETCH);

endmodule

// File: hw/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              fetch_valid,
    input  isa_pkg::word_t    read_data,
    output logic              ready,
    output isa_pkg::opcode_e  opcode,
    output logic [2:0]        funct3,
    output logic              funct7_bit,
    output logic [4:0]        rd,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output isa_pkg::word_t    imm
);

    isa_pkg::word_t insn;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            insn <= '0;
        end else if (fetch_valid) begin
            insn <= read_data;
        end
    end

    // fields decode straight from the held word within the cycle.
    assign ready      = enable;
    assign opcode     = isa_pkg::opcode_e'(insn[6:0]);
    assign rd         = insn[11:7];
    assign funct3     = insn[14:12];
    assign rs1        = insn[19:15];
    assign rs2        = insn[24:20];
    assign funct7_bit = insn[30];

    always_comb begin
        case (opcode)
            isa_pkg::OP_IMM, isa_pkg::LOAD: imm = {{20{insn[31]}}, insn[31:20]};
            isa_pkg::STORE:  imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            isa_pkg::BRANCH: imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
                                    insn[11:8], 1'b0};
            isa_pkg::LUI:    imm = {insn[31:12], 12'b0};
            isa_pkg::JAL:    imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20],
                                    insn[30:21], 1'b0};
            default:         imm = '0;
        endcase
    end

endmodule

// File: hw/pc.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module pc (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,
    input  logic            load,
    input  isa_pkg::word_t  target,
    output isa_pkg::word_t  value
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= `CPU_RESET_PC;
        end else if (load) begin
            value <= target;
        end else if (advance) begin
            value <= value + 32'd4;
        end
    end

    // writeback retires with exactly one kind of update.
    single_update: assert property (@(posedge clk) disable iff (!rst_n) !(advance && load));

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module register_file (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      read_addr1,
    input  logic [4:0]      read_addr2,
    output isa_pkg::word_t  read_data1,
    output isa_pkg::word_t  read_data2,
    input  logic            write_enable,
    input  logic [4:0]      write_addr,
    input  isa_pkg::word_t  write_data
);

    isa_pkg::word_t regs [`CPU_REG_COUNT];

    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    // x0 is never written, so it keeps its reset value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_e  op,
    input  isa_pkg::word_t    lhs,
    input  isa_pkg::word_t    rhs,
    output isa_pkg::word_t    res
);

    logic [4:0] shamt;

    assign shamt = rhs[4:0];

    always_comb begin
        case (op)
            isa_pkg::ADD: res = lhs + rhs;
            isa_pkg::SUB: res = lhs - rhs;
            isa_pkg::AND: res = lhs & rhs;
            isa_pkg::OR:  res = lhs | rhs;
            isa_pkg::XOR: res = lhs ^ rhs;
            isa_pkg::SLT: res = {31'b0, $signed(lhs) < $signed(rhs)};
            isa_pkg::SLL: res = lhs << shamt;
            isa_pkg::SRL: res = lhs >> shamt;
            default:      res = '0;
        endcase
    end

endmodule

// File: hw/core_pkg.sv
package core_pkg;

    // ####################
    // control sequencing
    // ####################

    // one instruction walks these in order and takes MEMORY only for loads and stores.
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } ctrl_state_e;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

    // ####################
    // words and opcodes
    // ####################

    typedef logic [31:0] word_t;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL
    } alu_op_e;

    // funct3 codes of the ALU group and of the branches.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;

endpackage

// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

// architectural integer registers.
`define CPU_REG_COUNT 32

`endif
